// ==== list.f ====
logic/fetch_pkg.sv
logic/fetch_requester.sv
logic/fetch_buf.sv
logic/predecode.sv
logic/fetch_top.sv
tests/fetch_checker.sv
tests/tb_fetch_top.sv

// ==== run.sh ====
#!/bin/sh
# build and run the fetch testbench with verilator.
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps -f list.f \
    --top-module tb_fetch_top -o sim_fetch
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_fetch > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation failed" "$LOG"; then
    exit 1
fi

exit 0

// ==== tests/tb_fetch_top.sv ====
`timescale 1ns/1ps

module tb_fetch_top;
    import fetch_pkg::*;

    localparam int MEM_WORDS   = 2 ** (ADDR_BITS - 2);
    localparam int TOTAL_INSTR = 5 * 200 + 50 + 100;
    localparam int CYCLE_LIMIT = 40 * TOTAL_INSTR;

    logic                 clk = 1'b0;
    logic                 rst_n;
    logic [ADDR_BITS-1:1] boot_pc;
    logic [ADDR_BITS-1:0] paddr;
    logic                 psel;
    logic                 penable;
    logic                 pwrite;
    logic [ILEN-1:0]      prdata = '0;
    logic                 pready = 1'b0;
    fetch_out_t           out;
    logic                 out_valid;
    logic                 out_ready = 1'b0;

    logic [ILEN-1:0]      mem [MEM_WORDS];
    logic [8*16-1:0]      test_name;
    int                   seed = 16640;
    int unsigned          ready_pct = 100;
    int unsigned          max_wait = 0;
    int                   wait_left = 0;
    int                   draw;
    int                   cycles = 0;
    int                   tb_errors = 0;
    int                   accepted;
    int                   straddles;
    int                   chk_errors;

    fetch_top
    #(
        .DEPTH_BITS  (2)
    )
    u_dut
    (
        .i_clk       (clk),
        .i_rst_n     (rst_n),
        .i_boot_pc   (boot_pc),
        .o_paddr     (paddr),
        .o_psel      (psel),
        .o_penable   (penable),
        .o_pwrite    (pwrite),
        .i_prdata    (prdata),
        .i_pready    (pready),
        .o_out       (out),
        .o_out_valid (out_valid),
        .i_out_ready (out_ready)
    );

    fetch_checker
    #(
        .MEM_WORDS   (MEM_WORDS)
    )
    u_chk
    (
        .i_clk       (clk),
        .i_rst_n     (rst_n),
        .i_boot_pc   (boot_pc),
        .i_mem       (mem),
        .i_test_name (test_name),
        .i_paddr     (paddr),
        .i_psel      (psel),
        .i_penable   (penable),
        .i_pwrite    (pwrite),
        .i_pready    (pready),
        .i_out       (out),
        .i_out_valid (out_valid),
        .i_out_ready (out_ready),
        .o_accepted  (accepted),
        .o_straddles (straddles),
        .o_errors    (chk_errors)
    );

    initial
    begin
        forever #4 clk = ~clk;
    end

    // one major opcode per entry, every class present.
    function automatic logic [4:0] opcode_for(input logic [3:0] k);
        logic [4:0] opc;
        case (k)
            4'd0:    opc = 5'b00000;
            4'd1:    opc = 5'b01000;
            4'd2:    opc = 5'b11000;
            4'd3:    opc = 5'b11011;
            4'd4:    opc = 5'b11001;
            4'd5:    opc = 5'b01100;
            4'd6:    opc = 5'b00100;
            4'd7:    opc = 5'b01101;
            4'd8:    opc = 5'b00101;
            4'd9:    opc = 5'b11100;
            4'd10:   opc = 5'b00011;
            default: opc = 5'b01011;
        endcase
        return opc;
    endfunction

    // about half of all halfwords come out compressed.
    function automatic logic [15:0] random_half();
        logic [31:0] r;
        logic [31:0] k;
        logic [15:0] h;
        r = $random(seed);
        k = {$random(seed)} % 12;
        h = r[15:0];
        if (r[16])
        begin
            h = {h[15:7], opcode_for(k[3:0]), 2'b11};
        end
        else if (h[1:0] == 2'b11)
        begin
            h[1:0] = {1'b0, r[17]};
        end
        return h;
    endfunction

    task automatic fill_memory();
        logic [15:0] lo;
        logic [15:0] hi;
        for (int w = 0; w < MEM_WORDS; w++)
        begin
            lo = random_half();
            hi = random_half();
            mem[w[ADDR_BITS-3:0]] = {hi, lo};
        end
    endtask

    task automatic run_test(input logic [8*16-1:0] name, input logic [ADDR_BITS-1:0] boot,
                            input int unsigned pct, input int unsigned waits, input int count);
        @(posedge clk);
        test_name <= name;
        ready_pct <= pct;
        max_wait  <= waits;
        boot_pc   <= boot[ADDR_BITS-1:1];
        rst_n     <= 1'b0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        while (accepted < count)
        begin
            @(posedge clk);
        end
    endtask

    // apb memory with 0 to max_wait wait states, plus random ready.
    always @(posedge clk)
    begin
        out_ready <= (({$random(seed)} % 100) < ready_pct);
        if (!rst_n)
        begin
            pready    <= 1'b0;
            wait_left <= 0;
        end
        else if (psel && !penable)
        begin
            draw = {$random(seed)} % (max_wait + 1);
            if (draw == 0)
            begin
                pready <= 1'b1;
                prdata <= mem[paddr[ADDR_BITS-1:2]];
            end
            else
            begin
                wait_left <= draw;
            end
        end
        else if (psel && penable)
        begin
            if (pready)
            begin
                pready <= 1'b0;
            end
            else if (wait_left <= 1)
            begin
                pready <= 1'b1;
                prdata <= mem[paddr[ADDR_BITS-1:2]];
            end
            else
            begin
                wait_left <= wait_left - 1;
            end
        end
    end

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT)
        begin
            $display("timeout: run still going after %0d cycles, %0d instructions in %0s",
                     CYCLE_LIMIT, accepted, test_name);
            $display("errors: checker %0d, testbench %0d", chk_errors, tb_errors + 1);
            $display("Simulation failed");
            $finish;
        end
    end

    initial
    begin
        rst_n     <= 1'b0;
        boot_pc   <= '0;
        test_name <= "startup";
        fill_memory();
        run_test("aligned", 16'h0100, 100, 0, 200);
        run_test("halfword_boot", 16'h0202, 100, 0, 200);
        run_test("straddle", 16'h0802, 100, 3, 200);
        if (straddles < 20)
        begin
            $display("straddle test saw only %0d split 32-bit instructions", straddles);
            tb_errors++;
        end
        run_test("backpressure", 16'h1000, 30, 0, 200);
        run_test("wait_states", 16'h2000, 100, 3, 200);
        run_test("restart_first", 16'h3000, 30, 3, 50);
        run_test("restart", 16'h0406, 60, 2, 100);
        @(posedge clk);
        $display("errors: checker %0d, testbench %0d", chk_errors, tb_errors);
        if (chk_errors + tb_errors == 0)
        begin
            $display("Simulation completed successfully");
        end
        else
        begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== tests/fetch_checker.sv ====
`timescale 1ns/1ps

module fetch_checker
#(
    parameter int MEM_WORDS = 16384
)
(
    input  logic                            i_clk,
    input  logic                            i_rst_n,
    input  logic [fetch_pkg::ADDR_BITS-1:1] i_boot_pc,
    input  logic [fetch_pkg::ILEN-1:0]      i_mem [MEM_WORDS],
    input  logic [8*16-1:0]                 i_test_name,
    input  logic [fetch_pkg::ADDR_BITS-1:0] i_paddr,
    input  logic                            i_psel,
    input  logic                            i_penable,
    input  logic                            i_pwrite,
    input  logic                            i_pready,
    input  fetch_pkg::fetch_out_t           i_out,
    input  logic                            i_out_valid,
    input  logic                            i_out_ready,
    output int                              o_accepted,
    output int                              o_straddles,
    output int                              o_errors
);
    import fetch_pkg::*;

    logic [ADDR_BITS-1:1] exp_pc;
    fetch_out_t           want;
    fetch_out_t           held;
    logic                 hold;
    logic                 prev_setup;
    logic                 prev_wait;
    logic [ADDR_BITS-1:0] prev_paddr;
    int                   errors = 0;

    function automatic logic [15:0] half_at(input logic [ADDR_BITS-1:0] addr);
        logic [ILEN-1:0] w;
        w = i_mem[addr[ADDR_BITS-1:2]];
        return addr[1] ? w[31:16] : w[15:0];
    endfunction

    function automatic op_class_e class_of(input logic [ILEN-1:0] ins, input logic comp);
        logic [4:0] opc;
        logic [2:0] f3;
        logic [1:0] quad;
        opc  = ins[6:2];
        f3   = ins[15:13];
        quad = ins[1:0];
        if (!comp)
        begin
            if (opc == 5'b00000) return OC_LOAD;
            if (opc == 5'b01000) return OC_STORE;
            if (opc == 5'b11000) return OC_BRANCH;
            if (opc == 5'b11011 || opc == 5'b11001) return OC_JUMP;
            if (opc == 5'b01100 || opc == 5'b00100) return OC_ALU;
            if (opc == 5'b01101 || opc == 5'b00101) return OC_ALU;
            if (opc == 5'b11100) return OC_SYSTEM;
            return OC_OTHER;
        end
        // c.lw/c.sw in quadrant 0, c.lwsp/c.swsp in quadrant 2.
        if (quad != 2'b01 && f3 == 3'b010) return OC_LOAD;
        if (quad != 2'b01 && f3 == 3'b110) return OC_STORE;
        if (quad == 2'b01 && (f3 == 3'b110 || f3 == 3'b111)) return OC_BRANCH;
        if (quad == 2'b01 && (f3 == 3'b001 || f3 == 3'b101)) return OC_JUMP;
        if (quad == 2'b10 && f3 == 3'b100 && ins[6:2] == 5'd0 && ins[11:7] != 5'd0)
        begin
            return OC_JUMP;
        end
        return OC_ALU;
    endfunction

    function automatic fetch_out_t expect_at(input logic [ADDR_BITS-1:1] pc);
        logic [ADDR_BITS-1:0] addr;
        logic [15:0]          lo;
        logic [15:0]          hi;
        fetch_out_t           e;
        addr      = {pc, 1'b0};
        lo        = half_at(addr);
        hi        = half_at(addr + ADDR_BITS'(2));
        e.pc      = pc;
        e.is_comp = (lo[1:0] != 2'b11);
        e.instr   = e.is_comp ? {16'h0000, lo} : {hi, lo};
        e.op_class = class_of(e.instr, e.is_comp);
        return e;
    endfunction

    always @(negedge i_clk)
    begin
        if (!i_rst_n)
        begin
            exp_pc      <= i_boot_pc;
            o_accepted  <= 0;
            o_straddles <= 0;
            hold        <= 1'b0;
            prev_setup  <= 1'b0;
            prev_wait   <= 1'b0;
        end
        else
        begin
            if (i_out_valid && i_out_ready)
            begin
                want = expect_at(exp_pc);
                if (i_out !== want)
                begin
                    $display("Mismatch %0s: expected %h, actual %h", i_test_name, want, i_out);
                    errors++;
                end
                if (exp_pc[1] && !want.is_comp)
                begin
                    o_straddles <= o_straddles + 1;
                end
                exp_pc     <= exp_pc + (want.is_comp ? (ADDR_BITS-1)'(1) : (ADDR_BITS-1)'(2));
                o_accepted <= o_accepted + 1;
            end
            if (hold && (!i_out_valid || i_out !== held))
            begin
                $display("%0s: output changed while waiting for ready", i_test_name);
                errors++;
            end
            hold <= i_out_valid && !i_out_ready;
            held <= i_out;

            if (i_pwrite || (i_penable && !i_psel))
            begin
                $display("%0s: bad apb control, write or enable without select", i_test_name);
                errors++;
            end
            if ((prev_setup || prev_wait) && !(i_psel && i_penable))
            begin
                $display("%0s: apb transfer left before pready", i_test_name);
                errors++;
            end
            if (i_penable && !prev_setup && !prev_wait)
            begin
                $display("%0s: apb access phase without a setup phase", i_test_name);
                errors++;
            end
            if ((prev_setup || prev_wait) && i_paddr !== prev_paddr)
            begin
                $display("%0s: apb address moved during a transfer", i_test_name);
                errors++;
            end
            prev_setup <= i_psel && !i_penable;
            prev_wait  <= i_psel && i_penable && !i_pready;
            prev_paddr <= i_paddr;
        end
    end

    assign o_errors = errors;

endmodule

// ==== logic/fetch_top.sv ====
`timescale 1ns/1ps

module fetch_top
#(
    parameter int DEPTH_BITS = 2
)
(
    input  logic                            i_clk,
    input  logic                            i_rst_n,
    input  logic [fetch_pkg::ADDR_BITS-1:1] i_boot_pc,
    output logic [fetch_pkg::ADDR_BITS-1:0] o_paddr,
    output logic                            o_psel,
    output logic                            o_penable,
    output logic                            o_pwrite,
    input  logic [fetch_pkg::ILEN-1:0]      i_prdata,
    input  logic                            i_pready,
    output fetch_pkg::fetch_out_t           o_out,
    output logic                            o_out_valid,
    input  logic                            i_out_ready
);
    import fetch_pkg::*;

    logic                 push;
    logic [ILEN-1:0]      push_data;
    logic                 not_full;
    logic [ILEN-1:0]      buf_data;
    logic [ADDR_BITS-1:1] buf_pc;
    logic                 not_empty;
    logic                 stall;

    fetch_requester
    #(
        .DEPTH_BITS  (DEPTH_BITS)
    )
    u_req
    (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_boot_pc   (i_boot_pc),
        .i_not_full  (not_full),
        .o_paddr     (o_paddr),
        .o_psel      (o_psel),
        .o_penable   (o_penable),
        .o_pwrite    (o_pwrite),
        .i_prdata    (i_prdata),
        .i_pready    (i_pready),
        .o_push      (push),
        .o_push_data (push_data)
    );

    fetch_buf
    #(
        .DEPTH_BITS  (DEPTH_BITS)
    )
    u_buf
    (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_stall     (stall),
        .i_pc        (i_boot_pc),
        .i_data      (push_data),
        .i_push      (push),
        .o_data      (buf_data),
        .o_pc        (buf_pc),
        .o_not_empty (not_empty),
        .o_not_full  (not_full)
    );

    predecode u_pre
    (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_data      (buf_data),
        .i_pc        (buf_pc),
        .i_not_empty (not_empty),
        .o_stall     (stall),
        .o_out       (o_out),
        .o_out_valid (o_out_valid),
        .i_out_ready (i_out_ready)
    );

endmodule

// ==== logic/predecode.sv ====
`timescale 1ns/1ps

module predecode
(
    input  logic                            i_clk,
    input  logic                            i_rst_n,
    input  logic [fetch_pkg::ILEN-1:0]      i_data,
    input  logic [fetch_pkg::ADDR_BITS-1:1] i_pc,
    input  logic                            i_not_empty,
    output logic                            o_stall,
    output fetch_pkg::fetch_out_t           o_out,
    output logic                            o_out_valid,
    input  logic                            i_out_ready
);
    import fetch_pkg::*;

    logic       is_comp;
    op_class_e  op_class;
    logic       load;
    fetch_out_t out_slot;
    logic       slot_valid;

    function automatic op_class_e class_32(input logic [4:0] opc);
        op_class_e cls;
        case (rv_opcode_e'(opc))
            OPC_LOAD:                                cls = OC_LOAD;
            OPC_STORE:                               cls = OC_STORE;
            OPC_BRANCH:                              cls = OC_BRANCH;
            OPC_JAL, OPC_JALR:                       cls = OC_JUMP;
            OPC_OP, OPC_OP_IMM, OPC_LUI, OPC_AUIPC:  cls = OC_ALU;
            OPC_SYSTEM:                              cls = OC_SYSTEM;
            default:                                 cls = OC_OTHER;
        endcase
        return cls;
    endfunction

    // quadrant in the top two bits of the key, funct3 below.
    function automatic op_class_e class_16(input logic [15:0] ci);
        op_class_e cls;
        case ({ci[1:0], ci[15:13]})
            5'b00_010, 5'b10_010: cls = OC_LOAD;
            5'b00_110, 5'b10_110: cls = OC_STORE;
            5'b01_110, 5'b01_111: cls = OC_BRANCH;
            5'b01_001, 5'b01_101: cls = OC_JUMP;
            // c.jr and c.jalr against c.mv, c.add and c.ebreak.
            5'b10_100:
            begin
                cls = (ci[6:2] == 5'd0 && ci[11:7] != 5'd0) ? OC_JUMP : OC_ALU;
            end
            default:              cls = OC_ALU;
        endcase
        return cls;
    endfunction

    assign is_comp  = (i_data[1:0] != 2'b11);
    assign op_class = is_comp ? class_16(i_data[15:0]) : class_32(i_data[6:2]);

    // slot refills in the cycle it empties.
    assign load    = !slot_valid || i_out_ready;
    assign o_stall = !load;

    always_ff @(posedge i_clk)
    begin
        if (!i_rst_n)
        begin
            slot_valid <= 1'b0;
        end
        else if (load)
        begin
            slot_valid <= i_not_empty;
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (load && i_not_empty)
        begin
            out_slot.pc       <= i_pc;
            out_slot.instr    <= is_comp ? {{(ILEN-16){1'b0}}, i_data[15:0]} : i_data;
            out_slot.is_comp  <= is_comp;
            out_slot.op_class <= op_class;
        end
    end

    assign o_out       = out_slot;
    assign o_out_valid = slot_valid;

endmodule

// ==== logic/fetch_buf.sv ====
`timescale 1ns/1ps

module fetch_buf
#(
    parameter int DEPTH_BITS = 2
)
(
    input  logic                            i_clk,
    input  logic                            i_rst_n,
    input  logic                            i_stall,
    input  logic [fetch_pkg::ADDR_BITS-1:1] i_pc,
    input  logic [fetch_pkg::ILEN-1:0]      i_data,
    input  logic                            i_push,
    output logic [fetch_pkg::ILEN-1:0]      o_data,
    output logic [fetch_pkg::ADDR_BITS-1:1] o_pc,
    output logic                            o_not_empty,
    output logic                            o_not_full
);
    import fetch_pkg::*;

    localparam int QSIZE = 2 ** DEPTH_BITS;

    logic [ILEN-1:0]      slot [QSIZE];
    logic [QSIZE:0]       is_head;

    logic [ADDR_BITS-1:1] pc;
    logic [ADDR_BITS-1:1] pc_step;
    logic [15:0]          latch_hi;
    logic                 hi_valid;

    logic                 have_word;
    logic [15:0]          data_lo;
    logic [15:0]          data_hi;
    logic                 is_comp;
    logic                 up_is_32;
    logic                 spill;
    logic                 not_empty;
    logic                 pop;
    logic                 consume;
    logic                 save_hi;

    assign have_word = !is_head[0];

    // hi_valid set means the halfword at pc sits in latch_hi, its word already gone.
    assign data_lo = !pc[1]   ? slot[0][15:0] :
                     hi_valid ? latch_hi      : slot[0][31:16];
    assign data_hi = (pc[1] && hi_valid) ? slot[0][15:0] : slot[0][31:16];

    assign is_comp  = (data_lo[1:0] != 2'b11);
    assign up_is_32 = (slot[0][17:16] == 2'b11);

    // only after a boot at an odd halfword.
    assign spill     = have_word && pc[1] && !hi_valid && !is_comp;
    assign not_empty = have_word && !spill;
    assign pop       = not_empty && !i_stall;

    // a word leaves the queue once nothing more is read from its low half.
    assign consume = spill ||
                     (pop && (pc[1] ? (!hi_valid || up_is_32) : (!is_comp || up_is_32)));

    // keep the upper half when a 32-bit instruction starts there.
    assign save_hi = spill ||
                     (pop && up_is_32 && (pc[1] ? hi_valid : is_comp));

    always_ff @(posedge i_clk)
    begin
        if (!i_rst_n)
        begin
            is_head <= {{QSIZE{1'b0}}, 1'b1};
        end
        else if (i_push && !consume)
        begin
            is_head <= is_head << 1;
        end
        else if (consume && !i_push)
        begin
            is_head <= is_head >> 1;
        end
    end

    generate
        for (genvar i = 0; i < QSIZE; i++)
        begin : g_slot
            logic take_new;

            // new word lands just above the remaining entries.
            assign take_new = i_push && (consume ? is_head[i+1] : is_head[i]);

            if (i == QSIZE - 1)
            begin : g_top
                always_ff @(posedge i_clk)
                begin
                    if (take_new)
                    begin
                        slot[i] <= i_data;
                    end
                end
            end
            else
            begin : g_mid
                always_ff @(posedge i_clk)
                begin
                    if (take_new)
                    begin
                        slot[i] <= i_data;
                    end
                    else if (consume)
                    begin
                        slot[i] <= slot[i+1];
                    end
                end
            end
        end
    endgenerate

    assign pc_step = is_comp ? (ADDR_BITS-1)'(1) : (ADDR_BITS-1)'(2);

    always_ff @(posedge i_clk)
    begin
        if (!i_rst_n)
        begin
            pc       <= i_pc;
            hi_valid <= 1'b0;
        end
        else
        begin
            if (pop)
            begin
                pc <= pc + pc_step;
            end
            if (spill || pop)
            begin
                hi_valid <= save_hi;
            end
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (save_hi)
        begin
            latch_hi <= slot[0][31:16];
        end
    end

    assign o_data      = {data_hi, data_lo};
    assign o_pc        = pc;
    assign o_not_empty = not_empty;
    // room is still there for a push when a word leaves in the same cycle.
    assign o_not_full  = !is_head[QSIZE] && !(is_head[QSIZE-1] && i_push && !consume);

endmodule

// ==== logic/fetch_requester.sv ====
`timescale 1ns/1ps

module fetch_requester
#(
    parameter int DEPTH_BITS = 2
)
(
    input  logic                            i_clk,
    input  logic                            i_rst_n,
    input  logic [fetch_pkg::ADDR_BITS-1:1] i_boot_pc,
    input  logic                            i_not_full,
    output logic [fetch_pkg::ADDR_BITS-1:0] o_paddr,
    output logic                            o_psel,
    output logic                            o_penable,
    output logic                            o_pwrite,
    input  logic [fetch_pkg::ILEN-1:0]      i_prdata,
    input  logic                            i_pready,
    output logic                            o_push,
    output logic [fetch_pkg::ILEN-1:0]      o_push_data
);
    import fetch_pkg::*;

    req_state_e            state;
    logic [ADDR_BITS-1:2]  word_addr;
    logic [DEPTH_BITS-1:0] burst_cnt;
    logic                  done;
    logic                  burst_end;

    assign done      = (state == RQ_ACCESS) && i_pready;
    assign burst_end = (burst_cnt == {DEPTH_BITS{1'b1}});

    // a queue's worth of words per burst, then the bus goes idle for a cycle.
    always_ff @(posedge i_clk)
    begin
        if (!i_rst_n)
        begin
            state     <= RQ_IDLE;
            word_addr <= i_boot_pc[ADDR_BITS-1:2];
            burst_cnt <= '0;
        end
        else
        begin
            case (state)
                RQ_IDLE:
                begin
                    if (i_not_full)
                    begin
                        state <= RQ_SETUP;
                    end
                end
                RQ_SETUP:
                begin
                    state <= RQ_ACCESS;
                end
                RQ_ACCESS:
                begin
                    if (i_pready)
                    begin
                        word_addr <= word_addr + (ADDR_BITS-2)'(1);
                        if (i_not_full && !burst_end)
                        begin
                            state     <= RQ_SETUP;
                            burst_cnt <= burst_cnt + DEPTH_BITS'(1);
                        end
                        else
                        begin
                            state     <= RQ_IDLE;
                            burst_cnt <= '0;
                        end
                    end
                end
                default:
                begin
                    state <= RQ_IDLE;
                end
            endcase
        end
    end

    // address and control hold through the access phase.
    assign o_paddr     = {word_addr, 2'b00};
    assign o_psel      = (state != RQ_IDLE);
    assign o_penable   = (state == RQ_ACCESS);
    assign o_pwrite    = 1'b0;

    assign o_push      = done;
    assign o_push_data = i_prdata;

endmodule

// ==== logic/fetch_pkg.sv ====
package fetch_pkg;

    // byte address width; pc values drop bit 0.
    localparam int ADDR_BITS = 16;

    localparam int ILEN = 32;

    typedef enum logic [2:0]
    {
        OC_LOAD,
        OC_STORE,
        OC_BRANCH,
        OC_JUMP,
        OC_ALU,
        OC_SYSTEM,
        OC_OTHER
    } op_class_e;

    typedef enum logic [1:0]
    {
        RQ_IDLE,
        RQ_SETUP,
        RQ_ACCESS
    } req_state_e;

    // major opcodes, bits 6 to 2 of a 32-bit instruction.
    typedef enum logic [4:0]
    {
        OPC_LOAD   = 5'b00000,
        OPC_OP_IMM = 5'b00100,
        OPC_AUIPC  = 5'b00101,
        OPC_STORE  = 5'b01000,
        OPC_OP     = 5'b01100,
        OPC_LUI    = 5'b01101,
        OPC_BRANCH = 5'b11000,
        OPC_JALR   = 5'b11001,
        OPC_JAL    = 5'b11011,
        OPC_SYSTEM = 5'b11100
    } rv_opcode_e;

    typedef struct packed
    {
        logic [ADDR_BITS-1:1] pc;
        logic [ILEN-1:0]      instr;
        logic                 is_comp;
        op_class_e            op_class;
    } fetch_out_t;

endpackage
